// File: sim.f
verilog/ex_pkg.sv
verilog/ex_issue_control.sv
verilog/ex_alu.sv
verilog/ex_multiplier.sv
verilog/ex_wb_register.sv
verilog/ex_stage.sv
testbench/ex_stage_properties.sv
testbench/tb_ex_stage.sv

// File: Makefile
TOOL      = verilator
FLAGS     = --binary --timing --assert
TOP       = tb_ex_stage
FILELIST  = sim.f
BUILD_DIR = obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

// File: testbench/ex_patterns.txt
// kind op smode a b c pc id_pc id_valid pc_if dit kill halt stall wdata dec target taken
// kind 0 alu, 1 alu branch, 2 multiply, 3 illegal, ff end of list
0 0 0 00000005 00000007 0 00000100 0 0 0 0 0 0 0 0000000c 0 0 0
0 1 0 00000003 00000005 0 00000104 0 0 0 0 0 0 0 fffffffe 0 0 0
0 2 0 f0f0f0f0 0ff00ff0 0 00000108 0 0 0 0 0 0 0 00f000f0 0 0 0
0 3 0 f0f0f0f0 0ff00ff0 0 0000010c 0 0 0 0 0 0 0 fff0fff0 0 0 0
0 4 0 f0f0f0f0 0ff00ff0 0 00000110 0 0 0 0 0 0 0 ff00ff00 0 0 0
0 5 0 00000001 00000024 0 00000114 0 0 0 0 0 0 0 00000010 0 0 0
0 6 0 80000000 00000004 0 00000118 0 0 0 0 0 0 0 08000000 0 0 0
0 7 0 80000000 00000004 0 0000011c 0 0 0 0 0 0 0 f8000000 0 0 0
0 8 0 ffffffff 00000001 0 00000120 0 0 0 0 0 0 0 00000001 0 0 0
0 9 0 ffffffff 00000001 0 00000124 0 0 0 0 0 0 0 00000000 0 0 0
0 a 0 00000005 00000005 0 00000128 0 0 0 0 0 0 0 00000001 0 0 0
0 b 0 00000005 00000005 0 0000012c 0 0 0 0 0 0 0 00000000 0 0 0
0 c 0 80000000 00000000 0 00000130 0 0 0 0 0 0 0 00000001 0 0 0
0 d 0 80000000 00000000 0 00000134 0 0 0 0 0 0 0 00000000 0 0 0
0 e 0 00000000 00000000 0 00000138 0 0 0 0 0 0 0 00000001 0 0 0
0 f 0 00000001 00000002 0 0000013c 0 0 0 0 0 0 0 00000000 0 0 0
0 0 0 00000010 00000020 0 00000140 0 0 0 0 0 0 3 00000030 0 0 0
1 a 0 00000007 00000007 00001000 00000200 0 0 0 0 0 0 0 0 1 00001000 1
1 b 0 00000007 00000007 00001100 00000204 0 0 0 0 0 0 0 0 0 00001100 0
1 c 0 fffffffe 00000001 00002000 00000208 0 0 0 0 0 0 0 0 1 00002000 1
1 f 0 00000001 00000002 00003000 0000020c 00000404 1 00000600 1 0 0 0 0 1 00000404 1
1 f 0 00000001 00000002 00003000 00000210 00000404 0 00000508 1 0 0 0 0 1 00000508 1
1 a 0 00000009 00000009 00003100 00000214 00000404 1 00000508 1 0 0 0 0 1 00003100 1
2 0 0 00000006 00000007 0 00000300 0 0 0 0 0 0 0 0000002a 0 0 0
2 1 0 ffffffff ffffffff 0 00000304 0 0 0 0 0 0 0 fffffffe 0 0 0
2 1 3 ffffffff 00000002 0 00000308 0 0 0 0 0 0 0 ffffffff 0 0 0
2 1 1 ffffffff ffffffff 0 0000030c 0 0 0 0 0 0 0 ffffffff 0 0 0
2 0 3 fffffffd 00000005 0 00000310 0 0 0 0 0 0 0 fffffff1 0 0 0
2 1 3 80000000 80000000 0 00000314 0 0 0 0 0 0 2 40000000 0 0 0
2 0 0 00001000 00001000 0 00000318 0 0 0 0 0 2 0 01000000 0 0 0
0 0 0 00000001 00000001 0 0000031c 0 0 0 0 0 3 0 00000002 0 0 0
0 0 0 00000005 00000006 0 00000320 0 0 0 0 1 0 0 0000000b 0 0 0
2 0 0 00000003 00000003 0 00000324 0 0 0 0 1 0 0 00000009 0 0 0
3 0 0 00000000 00000000 0 00000abc 0 0 0 0 0 0 0 00000000 0 0 0
ff 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0

// File: testbench/tb_ex_stage.sv
////////////////////////////////////////////////////////////
// Testbench for the execute stage
// Clock, reset, pattern file reader and instruction driver
// Ready and result waits with timeouts, one compare task
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_ex_stage;

  import ex_pkg::*;

  localparam int REC_W   = 18;
  localparam int MAX_REC = 64;
  localparam int TIMEOUT = 50;

  logic        clk;
  logic        rst_n;
  id_ex_pipe_t id_ex_pipe;
  if_id_pipe_t if_id_pipe;
  ctrl_fsm_t   ctrl_fsm;
  logic [31:0] pc_if;
  logic        dataindtiming;
  logic        wb_ready;
  ex_wb_pipe_t ex_wb_pipe;
  logic [31:0] rf_wdata;
  logic        branch_decision;
  logic [31:0] branch_target;
  logic        ex_ready;
  logic        ex_valid;

  // Pattern words, REC_W per instruction line
  logic [31:0] pat_mem [0:MAX_REC*REC_W-1];
  logic [31:0] rec [0:REC_W-1];

  ex_stage dut_i (
    .clk               (clk),
    .rst_n             (rst_n),
    .id_ex_pipe_i      (id_ex_pipe),
    .if_id_pipe_i      (if_id_pipe),
    .ctrl_fsm_i        (ctrl_fsm),
    .pc_if_i           (pc_if),
    .dataindtiming_i   (dataindtiming),
    .wb_ready_i        (wb_ready),
    .ex_wb_pipe_o      (ex_wb_pipe),
    .rf_wdata_o        (rf_wdata),
    .branch_decision_o (branch_decision),
    .branch_target_o   (branch_target),
    .ex_ready_o        (ex_ready),
    .ex_valid_o        (ex_valid)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // Overall limit on simulation time
  initial begin
    #200us;
    $display("SIMULATION FAILED");
    $fatal(1, "Simulation ran past its time limit");
  end

  ////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("[ERROR] %s: got 0x%08h, expected 0x%08h", name, got, exp);
      $display("SIMULATION FAILED");
      $fatal(1, "Value mismatch on %s", name);
    end
  endtask

  task automatic report_timeout(input string what);
    $display("SIMULATION FAILED");
    $fatal(1, "Timed out waiting for %s", what);
  endtask

  // Decoded instruction built from the current pattern line
  function automatic id_ex_pipe_t make_instr(input int n);
    id_ex_pipe_t p;
    logic [31:0] kind;
    kind              = rec[0];
    p                 = '0;
    p.instr_valid     = 1'b1;
    p.alu_en          = (kind == 32'd0) || (kind == 32'd1);
    p.mul_en          = (kind == 32'd2);
    p.alu_operator    = alu_op_e'(rec[1][4:0]);
    p.mul_operator    = mul_op_e'(rec[1][0]);
    p.mul_signed_mode = mul_sign_e'(rec[2][1:0]);
    p.operand_a       = rec[3];
    p.operand_b       = rec[4];
    p.operand_c       = rec[5];
    // Branches and illegal entries write no register
    p.rf_we           = (kind == 32'd0) || (kind == 32'd2);
    p.rf_waddr        = 5'((n % 31) + 1);
    p.pc              = rec[6];
    p.alu_bch         = (kind == 32'd1);
    p.illegal_insn    = (kind == 32'd3);
    return p;
  endfunction

  // Called at a falling edge, returns at a falling edge
  task automatic wait_ready();
    int cnt;
    cnt = 0;
    while (!ex_ready) begin
      if (cnt == TIMEOUT) begin
        report_timeout("ex_ready_o");
      end
      @(negedge clk);
      cnt++;
    end
  endtask

  task automatic wait_result();
    int cnt;
    cnt = 0;
    while (!ex_wb_pipe.instr_valid) begin
      if (cnt == TIMEOUT) begin
        report_timeout("a valid EX/WB entry");
      end
      @(negedge clk);
      cnt++;
    end
  endtask

  ////////////////////////////////////////////////////////////
  // One pattern line
  ////////////////////////////////////////////////////////////

  task automatic run_line(input int n);
    logic [31:0] kind;
    int          halt_cnt;
    int          stall_cnt;
    for (int k = 0; k < REC_W; k++) begin
      rec[k] = pat_mem[n*REC_W+k];
    end
    kind      = rec[0];
    halt_cnt  = int'(rec[12]);
    stall_cnt = int'(rec[13]);

    @(posedge clk);
    id_ex_pipe             <= make_instr(n);
    if_id_pipe.pc          <= rec[7];
    if_id_pipe.instr_valid <= rec[8][0];
    pc_if                  <= rec[9];
    dataindtiming          <= rec[10][0];
    ctrl_fsm.kill_ex       <= rec[11][0];
    ctrl_fsm.halt_ex       <= (halt_cnt != 0);
    wb_ready               <= (stall_cnt == 0);

    // Halted, EX must neither accept nor complete
    for (int h = 0; h < halt_cnt; h++) begin
      @(negedge clk);
      check("ex_ready_o while halted", 32'(ex_ready), 32'd0);
      check("ex_valid_o while halted", 32'(ex_valid), 32'd0);
      @(posedge clk);
      if (h == halt_cnt - 1) begin
        ctrl_fsm.halt_ex <= 1'b0;
      end
    end
    @(negedge clk);

    if (rec[11][0]) begin
      // Killed, drained at once and leaves only a bubble
      check("ex_ready_o on kill", 32'(ex_ready), 32'd1);
      check("ex_valid_o on kill", 32'(ex_valid), 32'd0);
      @(posedge clk);
      id_ex_pipe.instr_valid <= 1'b0;
      ctrl_fsm.kill_ex       <= 1'b0;
      @(negedge clk);
      check("instr_valid after kill", 32'(ex_wb_pipe.instr_valid), 32'd0);
    end else begin
      if (kind == 32'd1) begin
        check("branch_decision_o", 32'(branch_decision), rec[15]);
        check("branch_target_o", branch_target, rec[16]);
      end
      if (kind == 32'd2) begin
        check("ex_ready_o in first multiply cycle", 32'(ex_ready), 32'd0);
      end
      // WB stall, the bubble in EX/WB must stay
      for (int s = 0; s < stall_cnt; s++) begin
        check("instr_valid during stall", 32'(ex_wb_pipe.instr_valid), 32'd0);
        @(posedge clk);
        if (s == stall_cnt - 1) begin
          wb_ready <= 1'b1;
        end
        @(negedge clk);
      end
      wait_ready();
      // Accepting cycle, forwarding value already final
      check("ex_valid_o on accept", 32'(ex_valid), 32'd1);
      if (kind == 32'd0 || kind == 32'd2) begin
        check("rf_wdata_o", rf_wdata, rec[14]);
      end
      @(posedge clk);
      id_ex_pipe.instr_valid <= 1'b0;
      dataindtiming          <= 1'b0;
      @(negedge clk);
      wait_result();
      if (kind == 32'd0 || kind == 32'd2) begin
        check("rf_wdata", ex_wb_pipe.rf_wdata, rec[14]);
        check("rf_waddr", 32'(ex_wb_pipe.rf_waddr), 32'((n % 31) + 1));
      end
      check("rf_we", 32'(ex_wb_pipe.rf_we), 32'(kind == 32'd0 || kind == 32'd2));
      check("pc", ex_wb_pipe.pc, rec[6]);
      check("illegal_insn", 32'(ex_wb_pipe.illegal_insn), 32'(kind == 32'd3));
      // No jumps in the patterns
      check("alu_jmp_qual", 32'(ex_wb_pipe.alu_jmp_qual), 32'd0);
      check("alu_bch_qual", 32'(ex_wb_pipe.alu_bch_qual), 32'(kind == 32'd1));
      check("alu_bch_taken_qual", 32'(ex_wb_pipe.alu_bch_taken_qual), rec[17]);
      // Result shows up exactly once
      @(posedge clk);
      @(negedge clk);
      check("instr_valid after entry", 32'(ex_wb_pipe.instr_valid), 32'd0);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////

  initial begin
    int n;
    rst_n         = 1'b0;
    id_ex_pipe    = '0;
    if_id_pipe    = '0;
    ctrl_fsm      = '0;
    pc_if         = '0;
    dataindtiming = 1'b0;
    wb_ready      = 1'b1;
    $readmemh("testbench/ex_patterns.txt", pat_mem);

    repeat (8) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    check("instr_valid after reset", 32'(ex_wb_pipe.instr_valid), 32'd0);
    check("rf_we after reset", 32'(ex_wb_pipe.rf_we), 32'd0);
    check("alu_bch_taken_qual after reset", 32'(ex_wb_pipe.alu_bch_taken_qual), 32'd0);

    n = 0;
    while (n < MAX_REC && pat_mem[n*REC_W] !== 32'hff) begin
      run_line(n);
      n++;
    end
    check("pattern lines run", 32'(n > 0), 32'd1);

    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

// File: testbench/ex_stage_properties.sv
////////////////////////////////////////////////////////////
// Concurrent assertions on the EX/WB pipeline register
// Bound into every ex_wb_register instance
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module ex_stage_properties (
  input logic                clk,
  input logic                rst_n,
  input logic                wb_ready_i,
  input ex_pkg::ex_wb_pipe_t ex_wb_pipe_o
);

  // Register comes out of reset empty
  a_empty_after_reset: assert property (@(posedge clk)
    $rose(rst_n) |-> !ex_wb_pipe_o.instr_valid)
    else $error("EX/WB entry valid right after reset");

  // WB stall freezes the whole entry
  a_hold_on_stall: assert property (@(posedge clk) disable iff (!rst_n)
    !wb_ready_i |=> $stable(ex_wb_pipe_o))
    else $error("EX/WB entry changed while WB stalled");

  // A taken branch is always a qualified branch
  a_taken_is_branch: assert property (@(posedge clk) disable iff (!rst_n)
    ex_wb_pipe_o.alu_bch_taken_qual |-> ex_wb_pipe_o.alu_bch_qual)
    else $error("Taken qualifier set without branch qualifier");

endmodule

bind ex_wb_register ex_stage_properties props_i (
  .clk          (clk),
  .rst_n        (rst_n),
  .wb_ready_i   (wb_ready_i),
  .ex_wb_pipe_o (ex_wb_pipe_o)
);

// File: verilog/ex_stage.sv
////////////////////////////////////////////////////////////
// Execute stage top level
// Issue control, ALU, multiplier and EX/WB register
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module ex_stage (
  input  logic                    clk,
  input  logic                    rst_n,
  input  ex_pkg::id_ex_pipe_t     id_ex_pipe_i,
  input  ex_pkg::if_id_pipe_t     if_id_pipe_i,
  input  ex_pkg::ctrl_fsm_t       ctrl_fsm_i,
  input  logic [ex_pkg::XLEN-1:0] pc_if_i,
  input  logic                    dataindtiming_i,
  input  logic                    wb_ready_i,
  output ex_pkg::ex_wb_pipe_t     ex_wb_pipe_o,
  output logic [ex_pkg::XLEN-1:0] rf_wdata_o,
  output logic                    branch_decision_o,
  output logic [ex_pkg::XLEN-1:0] branch_target_o,
  output logic                    ex_ready_o,
  output logic                    ex_valid_o
);

  import ex_pkg::*;

  logic            instr_live;
  logic            mul_start;
  logic            mul_valid;
  logic            alu_cmp_result;
  logic [XLEN-1:0] alu_result;
  logic [XLEN-1:0] mul_result;

  ////////////////////////////////////////////////////////////
  // Issue control and branch resolution
  ////////////////////////////////////////////////////////////

  ex_issue_control issue_control_i (
    .id_ex_pipe_i      (id_ex_pipe_i),
    .if_id_pipe_i      (if_id_pipe_i),
    .ctrl_fsm_i        (ctrl_fsm_i),
    .pc_if_i           (pc_if_i),
    .dataindtiming_i   (dataindtiming_i),
    .cmp_result_i      (alu_cmp_result),
    .mul_valid_i       (mul_valid),
    .wb_ready_i        (wb_ready_i),
    .instr_live_o      (instr_live),
    .mul_start_o       (mul_start),
    .ex_valid_o        (ex_valid_o),
    .ex_ready_o        (ex_ready_o),
    .branch_decision_o (branch_decision_o),
    .branch_target_o   (branch_target_o)
  );

  ex_alu alu_i (
    .operator_i   (id_ex_pipe_i.alu_operator),
    .operand_a_i  (id_ex_pipe_i.operand_a),
    .operand_b_i  (id_ex_pipe_i.operand_b),
    .result_o     (alu_result),
    .cmp_result_o (alu_cmp_result)
  );

  // Result is released only when a live instruction hands it to WB,
  // so a halt keeps the product waiting
  ex_multiplier mult_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .start_i       (mul_start),
    .kill_i        (ctrl_fsm_i.kill_ex),
    .operator_i    (id_ex_pipe_i.mul_operator),
    .signed_mode_i (id_ex_pipe_i.mul_signed_mode),
    .op_a_i        (id_ex_pipe_i.operand_a),
    .op_b_i        (id_ex_pipe_i.operand_b),
    .ready_i       (wb_ready_i && instr_live),
    .result_o      (mul_result),
    .valid_o       (mul_valid)
  );

  ex_wb_register ex_wb_register_i (
    .clk               (clk),
    .rst_n             (rst_n),
    .id_ex_pipe_i      (id_ex_pipe_i),
    .alu_result_i      (alu_result),
    .mul_result_i      (mul_result),
    .branch_decision_i (branch_decision_o),
    .ex_valid_i        (ex_valid_o),
    .wb_ready_i        (wb_ready_i),
    .rf_wdata_o        (rf_wdata_o),
    .ex_wb_pipe_o      (ex_wb_pipe_o)
  );

endmodule

// File: verilog/ex_wb_register.sv
////////////////////////////////////////////////////////////
// EX/WB pipeline register
// Write data select, also used for forwarding
// Jump and branch qualification, load/bubble/hold rule
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module ex_wb_register (
  input  logic                    clk,
  input  logic                    rst_n,
  input  ex_pkg::id_ex_pipe_t     id_ex_pipe_i,
  input  logic [ex_pkg::XLEN-1:0] alu_result_i,
  input  logic [ex_pkg::XLEN-1:0] mul_result_i,
  input  logic                    branch_decision_i,
  input  logic                    ex_valid_i,
  input  logic                    wb_ready_i,
  output logic [ex_pkg::XLEN-1:0] rf_wdata_o,
  output ex_pkg::ex_wb_pipe_t     ex_wb_pipe_o
);

  // Write data mux, ALU result by default
  assign rf_wdata_o = id_ex_pipe_i.mul_en ? mul_result_i : alu_result_i;

  ////////////////////////////////////////////////////////////
  // Pipeline register
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ex_wb_pipe_o.instr_valid        <= 1'b0;
      ex_wb_pipe_o.rf_we              <= 1'b0;
      ex_wb_pipe_o.rf_waddr           <= '0;
      ex_wb_pipe_o.rf_wdata           <= '0;
      ex_wb_pipe_o.pc                 <= '0;
      ex_wb_pipe_o.illegal_insn       <= 1'b0;
      ex_wb_pipe_o.alu_jmp_qual       <= 1'b0;
      ex_wb_pipe_o.alu_bch_qual       <= 1'b0;
      ex_wb_pipe_o.alu_bch_taken_qual <= 1'b0;
    end else if (ex_valid_i && wb_ready_i) begin
      ex_wb_pipe_o.instr_valid <= 1'b1;
      ex_wb_pipe_o.rf_we       <= id_ex_pipe_i.rf_we;
      // Destination and data only move for register writes
      if (id_ex_pipe_i.rf_we) begin
        ex_wb_pipe_o.rf_waddr <= id_ex_pipe_i.rf_waddr;
        ex_wb_pipe_o.rf_wdata <= rf_wdata_o;
      end
      ex_wb_pipe_o.pc           <= id_ex_pipe_i.pc;
      ex_wb_pipe_o.illegal_insn <= id_ex_pipe_i.illegal_insn;
      // Jumps and branches only count when the ALU executed them
      ex_wb_pipe_o.alu_jmp_qual <= id_ex_pipe_i.alu_jmp && id_ex_pipe_i.alu_en;
      ex_wb_pipe_o.alu_bch_qual <= id_ex_pipe_i.alu_bch && id_ex_pipe_i.alu_en;
      ex_wb_pipe_o.alu_bch_taken_qual <= id_ex_pipe_i.alu_bch && id_ex_pipe_i.alu_en &&
                                         branch_decision_i;
    end else if (wb_ready_i) begin
      // WB free but nothing finished here, insert a bubble
      ex_wb_pipe_o.instr_valid <= 1'b0;
    end
  end

endmodule

// File: verilog/ex_multiplier.sv
////////////////////////////////////////////////////////////
// Two-cycle multiplier
// MUL and MULH/MULHSU/MULHU via sign-extended operands
// Idle/done FSM, result held until WB takes it
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module ex_multiplier (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    start_i,
  input  logic                    kill_i,
  input  ex_pkg::mul_op_e         operator_i,
  input  ex_pkg::mul_sign_e       signed_mode_i,
  input  logic [ex_pkg::XLEN-1:0] op_a_i,
  input  logic [ex_pkg::XLEN-1:0] op_b_i,
  input  logic                    ready_i,
  output logic [ex_pkg::XLEN-1:0] result_o,
  output logic                    valid_o
);

  import ex_pkg::*;

  typedef enum logic {
    MUL_IDLE = 1'b0,
    MUL_DONE = 1'b1
  } mul_state_e;

  mul_state_e               state_q;
  mul_state_e               state_d;
  logic signed [XLEN:0]     a_ext;
  logic signed [XLEN:0]     b_ext;
  logic signed [2*XLEN+1:0] product;
  logic [XLEN-1:0]          result_q;

  // One extra bit per operand covers all three signed modes
  assign a_ext   = {(signed_mode_i != MUL_UU) & op_a_i[XLEN-1], op_a_i};
  assign b_ext   = {(signed_mode_i == MUL_SS) & op_b_i[XLEN-1], op_b_i};
  assign product = a_ext * b_ext;

  ////////////////////////////////////////////////////////////
  // FSM
  ////////////////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      MUL_IDLE: if (start_i) state_d = MUL_DONE;
      // Leave once WB accepts, or drop the result on kill
      MUL_DONE: if (kill_i || ready_i) state_d = MUL_IDLE;
      default:  state_d = MUL_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= MUL_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Capture the selected word in the first cycle
  always_ff @(posedge clk) begin
    if ((state_q == MUL_IDLE) && start_i) begin
      result_q <= (operator_i == MUL_H) ? product[2*XLEN-1:XLEN] : product[XLEN-1:0];
    end
  end

  assign result_o = result_q;
  assign valid_o  = (state_q == MUL_DONE);

endmodule

// File: verilog/ex_alu.sv
////////////////////////////////////////////////////////////
// Single-cycle ALU
// Add, subtract, logic and shift operations
// Signed and unsigned compares on one shared subtractor
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module ex_alu (
  input  ex_pkg::alu_op_e         operator_i,
  input  logic [ex_pkg::XLEN-1:0] operand_a_i,
  input  logic [ex_pkg::XLEN-1:0] operand_b_i,
  output logic [ex_pkg::XLEN-1:0] result_o,
  output logic                    cmp_result_o
);

  import ex_pkg::*;

  // a - b with carry out, one bit wider than XLEN
  logic [XLEN:0]   diff;
  logic [XLEN-1:0] sum;
  logic [4:0]      shamt;
  logic            is_equal;
  logic            is_less;
  logic            is_less_u;

  assign sum   = operand_a_i + operand_b_i;
  assign diff  = {1'b0, operand_a_i} + {1'b0, ~operand_b_i} + {{XLEN{1'b0}}, 1'b1};
  assign shamt = operand_b_i[4:0];

  ////////////////////////////////////////////////////////////
  // Compare flags
  ////////////////////////////////////////////////////////////

  assign is_equal  = (diff[XLEN-1:0] == '0);
  // No carry out means a borrow, so a < b unsigned
  assign is_less_u = ~diff[XLEN];
  // Differing signs decide directly, else the difference sign does
  assign is_less   = (operand_a_i[XLEN-1] != operand_b_i[XLEN-1]) ?
                     operand_a_i[XLEN-1] : diff[XLEN-1];

  always_comb begin
    unique case (operator_i)
      ALU_EQ:            cmp_result_o = is_equal;
      ALU_NE:            cmp_result_o = !is_equal;
      ALU_LT, ALU_SLT:   cmp_result_o = is_less;
      ALU_LTU, ALU_SLTU: cmp_result_o = is_less_u;
      ALU_GE:            cmp_result_o = !is_less;
      ALU_GEU:           cmp_result_o = !is_less_u;
      default:           cmp_result_o = 1'b0;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // Result mux
  ////////////////////////////////////////////////////////////

  always_comb begin
    unique case (operator_i)
      ALU_ADD: result_o = sum;
      ALU_SUB: result_o = diff[XLEN-1:0];
      ALU_AND: result_o = operand_a_i & operand_b_i;
      ALU_OR:  result_o = operand_a_i | operand_b_i;
      ALU_XOR: result_o = operand_a_i ^ operand_b_i;
      ALU_SLL: result_o = operand_a_i << shamt;
      ALU_SRL: result_o = operand_a_i >> shamt;
      // Arithmetic shift keeps the sign bit
      ALU_SRA: result_o = $unsigned($signed(operand_a_i) >>> shamt);
      // Compares return the flag zero extended
      default: result_o = {{(XLEN-1){1'b0}}, cmp_result_o};
    endcase
  end

endmodule

// File: verilog/ex_issue_control.sv
////////////////////////////////////////////////////////////
// EX issue control
// Kill and halt gating of the current instruction
// Stage valid and ready
// Branch decision and target, incl. data-independent timing
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module ex_issue_control (
  input  ex_pkg::id_ex_pipe_t    id_ex_pipe_i,
  input  ex_pkg::if_id_pipe_t    if_id_pipe_i,
  input  ex_pkg::ctrl_fsm_t      ctrl_fsm_i,
  input  logic [ex_pkg::XLEN-1:0] pc_if_i,
  input  logic                   dataindtiming_i,
  input  logic                   cmp_result_i,
  input  logic                   mul_valid_i,
  input  logic                   wb_ready_i,
  output logic                   instr_live_o,
  output logic                   mul_start_o,
  output logic                   ex_valid_o,
  output logic                   ex_ready_o,
  output logic                   branch_decision_o,
  output logic [ex_pkg::XLEN-1:0] branch_target_o
);

  // Instruction present and not blocked by the controller
  assign instr_live_o = id_ex_pipe_i.instr_valid && !ctrl_fsm_i.kill_ex && !ctrl_fsm_i.halt_ex;

  // Multiplier only starts on a live instruction
  assign mul_start_o = id_ex_pipe_i.mul_en && instr_live_o;

  ////////////////////////////////////////////////////////////
  // Stage handshake levels
  ////////////////////////////////////////////////////////////

  // ALU is single cycle, multiply needs mul_valid
  // Illegal instructions from ID still go to WB as a valid entry
  assign ex_valid_o = (id_ex_pipe_i.alu_en ||
                       (id_ex_pipe_i.mul_en && mul_valid_i) ||
                       id_ex_pipe_i.illegal_insn) && instr_live_o;

  // Kill always drains EX; otherwise wait on WB and an unfinished multiply
  assign ex_ready_o = ctrl_fsm_i.kill_ex ||
                      (!ctrl_fsm_i.halt_ex && wb_ready_i && !(mul_start_o && !mul_valid_i));

  ////////////////////////////////////////////////////////////
  // Branch resolution
  ////////////////////////////////////////////////////////////

  always_comb begin
    if (dataindtiming_i) begin
      // Always redirect so the fetch timing does not depend on the outcome
      branch_decision_o = 1'b1;
      if (cmp_result_i) begin
        branch_target_o = id_ex_pipe_i.operand_c;
      end else if (if_id_pipe_i.instr_valid) begin
        // Not taken, refetch from the instruction in ID
        branch_target_o = if_id_pipe_i.pc;
      end else begin
        // ID empty, continue from IF
        branch_target_o = pc_if_i;
      end
    end else begin
      branch_decision_o = cmp_result_i;
      branch_target_o   = id_ex_pipe_i.operand_c;
    end
  end

endmodule

// File: verilog/ex_pkg.sv
////////////////////////////////////////////////////////////
// Shared definitions for the execute stage
// Data and register index widths
// ALU and multiplier opcode enums
// ID/EX, EX/WB, IF/ID and controller structs
////////////////////////////////////////////////////////////

package ex_pkg;

  // Data and address width
  parameter int unsigned XLEN       = 32;
  // Register file index width
  parameter int unsigned REG_ADDR_W = 5;

  ////////////////////////////////////////////////////////////
  // Opcodes
  ////////////////////////////////////////////////////////////

  // ALU operations, compares last
  typedef enum logic [4:0] {
    ALU_ADD  = 5'd0,
    ALU_SUB  = 5'd1,
    ALU_AND  = 5'd2,
    ALU_OR   = 5'd3,
    ALU_XOR  = 5'd4,
    ALU_SLL  = 5'd5,
    ALU_SRL  = 5'd6,
    ALU_SRA  = 5'd7,
    ALU_SLT  = 5'd8,
    ALU_SLTU = 5'd9,
    ALU_EQ   = 5'd10,
    ALU_NE   = 5'd11,
    ALU_LT   = 5'd12,
    ALU_LTU  = 5'd13,
    ALU_GE   = 5'd14,
    ALU_GEU  = 5'd15
  } alu_op_e;

  // Word of the product that is returned
  typedef enum logic {
    MUL_L = 1'b0,
    MUL_H = 1'b1
  } mul_op_e;

  // Bit 0 marks operand a signed, bit 1 marks operand b signed
  typedef enum logic [1:0] {
    MUL_UU = 2'b00,
    MUL_SU = 2'b01,
    MUL_SS = 2'b11
  } mul_sign_e;

  ////////////////////////////////////////////////////////////
  // Pipeline structs
  ////////////////////////////////////////////////////////////

  // Decoded instruction held in the ID/EX register
  typedef struct packed {
    logic                  instr_valid;
    logic                  alu_en;
    logic                  mul_en;
    alu_op_e               alu_operator;
    mul_op_e               mul_operator;
    mul_sign_e             mul_signed_mode;
    logic [XLEN-1:0]       operand_a;
    logic [XLEN-1:0]       operand_b;
    // Branch or jump target
    logic [XLEN-1:0]       operand_c;
    logic                  rf_we;
    logic [REG_ADDR_W-1:0] rf_waddr;
    logic [XLEN-1:0]       pc;
    logic                  alu_bch;
    logic                  alu_jmp;
    logic                  illegal_insn;
  } id_ex_pipe_t;

  // Result handed over to WB
  typedef struct packed {
    logic                  instr_valid;
    logic                  rf_we;
    logic [REG_ADDR_W-1:0] rf_waddr;
    logic [XLEN-1:0]       rf_wdata;
    logic [XLEN-1:0]       pc;
    logic                  illegal_insn;
    logic                  alu_jmp_qual;
    logic                  alu_bch_qual;
    logic                  alu_bch_taken_qual;
  } ex_wb_pipe_t;

  // Controller requests towards EX
  typedef struct packed {
    logic kill_ex;
    logic halt_ex;
  } ctrl_fsm_t;

  // Instruction currently sitting in ID
  typedef struct packed {
    logic [XLEN-1:0] pc;
    logic            instr_valid;
  } if_id_pipe_t;

endpackage
